// ==== run_sim.sh ====
#!/bin/bash
# Build and run the testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module top_level_tb -o top_level_tb_sim

./obj_dir/top_level_tb_sim 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0

// ==== sim.f ====
source/pov_pkg.sv
source/detect_to_theta.sv
source/frame_manager.sv
source/hub75_output.sv
source/top_level.sv
tb/top_level_properties.sv
tb/top_level_tb.sv

// ==== source/detect_to_theta.sv ====
`timescale 1ns/1ps
`default_nettype none

module detect_to_theta #(
    parameter int ROTATIONAL_RES = 180
) (
    input  wire                          clk_in,
    input  wire                          reset,
    input  wire                          ir_tripped,
    output logic [pov_pkg::THETA_W-1:0]  theta,
    output logic                         locked
);
    import pov_pkg::*;

    localparam logic [THETA_W-1:0]  THETA_MAX = THETA_W'(ROTATIONAL_RES - 1);
    localparam logic [PERIOD_W:0]   RES_STEP  = (PERIOD_W + 1)'(ROTATIONAL_RES);

    logic [1:0]          ir_sync;    // Two-flop synchroniser
    logic                trip;
    logic                seen_trip;  // First trip only starts the measurement
    logic [PERIOD_W-1:0] count;      // Cycles since the last trip
    logic [PERIOD_W-1:0] period;     // Length of the last full revolution
    logic [PERIOD_W:0]   acc;        // Fraction of the current slice
    logic [PERIOD_W:0]   acc_sum;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ir_sync <= '0;
        end else begin
            ir_sync <= {ir_sync[0], ir_tripped};
        end
    end

    // Rising edge of the synchronised level as it enters the second stage
    assign trip = ir_sync[0] & ~ir_sync[1];

    assign acc_sum = acc + RES_STEP;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            count     <= '0;
            period    <= '1;
            seen_trip <= 1'b0;
            locked    <= 1'b0;
            acc       <= '0;
            theta     <= '0;
        end else if (trip) begin
            period    <= count;
            count     <= PERIOD_W'(1);  // Trip cycle counts toward the next turn
            seen_trip <= 1'b1;
            acc       <= '0;
            theta     <= '0;
            if (seen_trip) begin
                locked <= 1'b1;  // A full period is now known
            end
        end else begin
            if (count != '1) begin
                count <= count + 1'b1;  // Saturates on a stalled rotor
            end

            // Slice advances each time RES/period of a turn has elapsed
            if (locked) begin
                if (acc_sum >= {1'b0, period}) begin
                    acc <= acc_sum - {1'b0, period};
                    if (theta != THETA_MAX) begin
                        theta <= theta + 1'b1;
                    end
                end else begin
                    acc <= acc_sum;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_manager #(
    parameter int ROTATIONAL_RES = 180,
    parameter int NUM_ROWS       = 64
) (
    input  wire                                     clk_in,
    input  wire                                     reset,
    input  wire pov_pkg::mode_t                     mode,
    input  wire [pov_pkg::THETA_W-1:0]              theta,
    input  wire                                     locked,
    output pov_pkg::slice_t                         slice,
    output pov_pkg::pixel_t [NUM_ROWS-1:0]          column0,
    output pov_pkg::pixel_t [NUM_ROWS-1:0]          column1,
    output logic                                    tvalid,
    input  wire                                     tready
);
    import pov_pkg::*;

    logic                        seen;        // A slice has been captured since reset
    logic [THETA_W-1:0]          pend_theta;  // Latest slice waiting for the output side
    logic                        pend_valid;
    logic                        load;
    logic [THETA_W-1:0]          opp_theta;
    pixel_t [NUM_ROWS-1:0]       col_a;
    pixel_t [NUM_ROWS-1:0]       col_b;

    // Pixel rule computed from slice and row
    function automatic pixel_t make_pixel(input mode_t m, input logic [THETA_W-1:0] t,
                                          input int row);
        pixel_t                p;
        logic [COLOR_BITS-1:0] tv;
        logic [COLOR_BITS-1:0] iv;
        tv = t[COLOR_BITS-1:0];
        iv = row[COLOR_BITS-1:0];
        case (m)
            MODE_SPHERE: begin
                p.r = tv;
                p.g = iv;
                p.b = tv ^ iv;
            end
            default: begin
                // Lit on even rows only
                p.r = row[0] ? '0 : tv;
                p.g = row[0] ? '0 : tv;
                p.b = row[0] ? '0 : tv;
            end
        endcase
        return p;
    endfunction

    always_comb begin
        int unsigned opp;
        opp = int'(pend_theta) + ROTATIONAL_RES / 2;
        if (opp >= ROTATIONAL_RES) begin
            opp = opp - ROTATIONAL_RES;
        end
        opp_theta = THETA_W'(opp);
        for (int i = 0; i < NUM_ROWS; i++) begin
            col_a[i] = make_pixel(mode, pend_theta, i);
            col_b[i] = make_pixel(mode, opp_theta, i);
        end
    end

    // Output register is free, or is emptied in this same cycle
    assign load = pend_valid && (!tvalid || tready);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            seen       <= 1'b0;
            pend_theta <= '0;
            pend_valid <= 1'b0;
            tvalid     <= 1'b0;
        end else begin
            // Newer theta overwrites any slice still pending
            if (locked && (!seen || theta != pend_theta)) begin
                pend_theta <= theta;
                pend_valid <= 1'b1;
                seen       <= 1'b1;
            end else if (load) begin
                pend_valid <= 1'b0;
            end

            if (load) begin
                tvalid <= 1'b1;
            end else if (tready) begin
                tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (load) begin
            slice.theta0 <= pend_theta;
            slice.theta1 <= opp_theta;
            column0      <= col_a;
            column1      <= col_b;
        end
    end

endmodule

`default_nettype wire

// ==== source/hub75_output.sv ====
`timescale 1ns/1ps
`default_nettype none

module hub75_output #(
    parameter int NUM_ROWS  = 64,
    parameter int SCAN_RATE = 32,
    parameter int BASE_TIME = 4
) (
    input  wire                                 clk_in,
    input  wire                                 reset,
    input  wire pov_pkg::slice_t                slice,
    input  wire pov_pkg::pixel_t [NUM_ROWS-1:0] column0,
    input  wire pov_pkg::pixel_t [NUM_ROWS-1:0] column1,
    input  wire                                 tvalid,
    output logic                                tready,
    output logic [4:0]                          addr,
    output logic [2:0]                          rgb0,
    output logic [2:0]                          rgb1,
    output logic                                latch,
    output logic                                output_enable,
    output logic                                led_clk
);
    import pov_pkg::*;

    localparam int ROW_W   = $clog2(NUM_ROWS);
    localparam int PLANE_W = $clog2(COLOR_BITS);
    localparam int OE_W    = $clog2(BASE_TIME << (COLOR_BITS - 1));

    localparam logic [ROW_W-1:0]   ROW_LAST   = ROW_W'(NUM_ROWS - 1);
    localparam logic [PLANE_W-1:0] PLANE_LAST = PLANE_W'(COLOR_BITS - 1);

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        LATCH,
        ENABLE
    } state_t;

    state_t                state;
    logic [PLANE_W-1:0]    plane;   // Bit plane being shown
    logic [ROW_W-1:0]      row;     // Pixel being shifted
    logic [OE_W-1:0]       oe_cnt;  // Remaining enable cycles
    logic                  fire;
    pixel_t [NUM_ROWS-1:0] col0_q;
    pixel_t [NUM_ROWS-1:0] col1_q;

    assign tready = (state == IDLE);
    assign fire   = tvalid && tready;

    // R in bit 2, B in bit 0
    assign rgb0 = {col0_q[row].r[plane], col0_q[row].g[plane], col0_q[row].b[plane]};
    assign rgb1 = {col1_q[row].r[plane], col1_q[row].g[plane], col1_q[row].b[plane]};

    always_ff @(posedge clk_in) begin
        if (fire) begin
            col0_q <= column0;
            col1_q <= column1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state         <= IDLE;
            plane         <= '0;
            row           <= '0;
            oe_cnt        <= '0;
            addr          <= '0;
            latch         <= 1'b0;
            output_enable <= 1'b1;
            led_clk       <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (fire) begin
                        addr  <= 5'(slice.theta0 % SCAN_RATE);  // Held for the frame
                        plane <= '0;
                        row   <= '0;
                        state <= SHIFT;
                    end
                end

                SHIFT: begin
                    // One low and one high cycle per pixel
                    if (!led_clk) begin
                        led_clk <= 1'b1;
                    end else begin
                        led_clk <= 1'b0;
                        if (row == ROW_LAST) begin
                            latch <= 1'b1;
                            state <= LATCH;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end
                end

                LATCH: begin
                    latch         <= 1'b0;
                    output_enable <= 1'b0;
                    oe_cnt        <= OE_W'((BASE_TIME << plane) - 1);  // Weight doubles per plane
                    state         <= ENABLE;
                end

                ENABLE: begin
                    if (oe_cnt == '0) begin
                        output_enable <= 1'b1;
                        row           <= '0;
                        if (plane == PLANE_LAST) begin
                            state <= IDLE;
                        end else begin
                            plane <= plane + 1'b1;
                            state <= SHIFT;
                        end
                    end else begin
                        oe_cnt <= oe_cnt - 1'b1;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/pov_pkg.sv ====
`default_nettype none

package pov_pkg;

    // Three bit planes per channel on the panel
    localparam int COLOR_BITS = 3;

    // Wide enough for several seconds per revolution at board clock rates
    localparam int PERIOD_W = 27;

    localparam int THETA_W = 8;  // Slice index for up to 256 slices

    // One panel pixel with R in the upper bits
    typedef struct packed {
        logic [COLOR_BITS-1:0] r;
        logic [COLOR_BITS-1:0] g;
        logic [COLOR_BITS-1:0] b;
    } pixel_t;

    // Slice pair for the two arms of the rotor
    typedef struct packed {
        logic [THETA_W-1:0] theta0;  // Front arm
        logic [THETA_W-1:0] theta1;  // Arm half a turn away
    } slice_t;

    typedef enum logic [1:0] {
        MODE_STRIPES = 2'd0,
        MODE_SPHERE  = 2'd1
    } mode_t;

endpackage

`default_nettype wire

// ==== source/top_level.sv ====
`timescale 1ns/1ps
`default_nettype none

module top_level #(
    parameter int ROTATIONAL_RES = 180,
    parameter int NUM_ROWS       = 64,
    parameter int SCAN_RATE      = 32,
    parameter int BASE_TIME      = 4
) (
    input  wire                 sysclk,
    input  wire                 reset,
    input  wire                 ir_tripped,     // IR gate on the PMOD header
    input  wire pov_pkg::mode_t mode,
    output logic [1:0]          led,
    output logic [4:0]          hub75_addr,
    output logic [2:0]          hub75_rgb0,
    output logic [2:0]          hub75_rgb1,
    output logic                hub75_latch,
    output logic                hub75_oe,       // Active low
    output logic                hub75_clk
);
    import pov_pkg::*;

    logic [THETA_W-1:0]    theta;
    logic                  locked;
    slice_t                slice;
    pixel_t [NUM_ROWS-1:0] column0;
    pixel_t [NUM_ROWS-1:0] column1;
    logic                  tvalid;
    logic                  tready;

    assign led = {locked, ir_tripped};  // LED 0 shows the raw gate

    detect_to_theta #(
        .ROTATIONAL_RES(ROTATIONAL_RES)
    ) dt (
        .clk_in    (sysclk),
        .reset     (reset),
        .ir_tripped(ir_tripped),
        .theta     (theta),
        .locked    (locked)
    );

    frame_manager #(
        .ROTATIONAL_RES(ROTATIONAL_RES),
        .NUM_ROWS      (NUM_ROWS)
    ) fm (
        .clk_in (sysclk),
        .reset  (reset),
        .mode   (mode),
        .theta  (theta),
        .locked (locked),
        .slice  (slice),
        .column0(column0),
        .column1(column1),
        .tvalid (tvalid),
        .tready (tready)
    );

    hub75_output #(
        .NUM_ROWS (NUM_ROWS),
        .SCAN_RATE(SCAN_RATE),
        .BASE_TIME(BASE_TIME)
    ) hub75 (
        .clk_in       (sysclk),
        .reset        (reset),
        .slice        (slice),
        .column0      (column0),
        .column1      (column1),
        .tvalid       (tvalid),
        .tready       (tready),
        .addr         (hub75_addr),
        .rgb0         (hub75_rgb0),
        .rgb1         (hub75_rgb1),
        .latch        (hub75_latch),
        .output_enable(hub75_oe),
        .led_clk      (hub75_clk)
    );

endmodule

`default_nettype wire

// ==== tb/top_level_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module top_level_properties (
    input wire       sysclk,
    input wire       reset,
    input wire [4:0] hub75_addr,
    input wire       hub75_latch,
    input wire       hub75_oe,
    input wire       hub75_clk
);

    // Latch is a single-cycle strobe
    latch_one_cycle: assert property (
        @(posedge sysclk) disable iff (reset)
        hub75_latch |=> !hub75_latch
    ) else $error("hub75_latch high for more than one cycle");

    // Panel stays blanked while shifting
    oe_off_while_shifting: assert property (
        @(posedge sysclk) disable iff (reset)
        (hub75_clk != $past(hub75_clk)) |-> hub75_oe
    ) else $error("hub75_oe low while hub75_clk toggles");

    addr_stable_when_lit: assert property (
        @(posedge sysclk) disable iff (reset)
        !hub75_oe |-> $stable(hub75_addr)
    ) else $error("hub75_addr changed while hub75_oe low");

endmodule

bind top_level top_level_properties props (
    .sysclk     (sysclk),
    .reset      (reset),
    .hub75_addr (hub75_addr),
    .hub75_latch(hub75_latch),
    .hub75_oe   (hub75_oe),
    .hub75_clk  (hub75_clk)
);

`default_nettype wire

// ==== tb/top_level_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module top_level_tb;
    import pov_pkg::*;

    localparam int ROTATIONAL_RES = 12;
    localparam int NUM_ROWS       = 8;
    localparam int SCAN_RATE      = 32;
    localparam int BASE_TIME      = 4;
    localparam int NUM_ENTRIES    = 7;
    localparam int RESET_CYCLES   = 16;

    // One revolution of stimulus with its expected slice count
    typedef struct packed {
        int    cycles;  // Revolution length
        mode_t mode;
        int    slices;  // Distinct slices expected
    } rev_entry_t;

    logic       sysclk = 1'b0;
    logic       reset;
    logic       ir_tripped;
    mode_t      mode;
    logic [1:0] led;
    logic [4:0] hub75_addr;
    logic [2:0] hub75_rgb0;
    logic [2:0] hub75_rgb1;
    logic       hub75_latch;
    logic       hub75_oe;
    logic       hub75_clk;

    rev_entry_t rev_table [NUM_ENTRIES];

    int          limit_cycles = 0;
    logic [31:0] rng_state    = 32'd52;
    int          frame_slices [$];  // Slice index of every decoded frame

    // Panel decoder state
    logic [2:0] bits0 [3][NUM_ROWS];
    logic [2:0] bits1 [3][NUM_ROWS];
    int         shift_cnt;
    int         plane;
    int         oe_len;
    int         latch_cnt;
    logic       clk_q;
    logic       oe_q;
    logic [4:0] frame_addr;

    top_level #(
        .ROTATIONAL_RES(ROTATIONAL_RES),
        .NUM_ROWS      (NUM_ROWS),
        .SCAN_RATE     (SCAN_RATE),
        .BASE_TIME     (BASE_TIME)
    ) UUT (
        .sysclk     (sysclk),
        .reset      (reset),
        .ir_tripped (ir_tripped),
        .mode       (mode),
        .led        (led),
        .hub75_addr (hub75_addr),
        .hub75_rgb0 (hub75_rgb0),
        .hub75_rgb1 (hub75_rgb1),
        .hub75_latch(hub75_latch),
        .hub75_oe   (hub75_oe),
        .hub75_clk  (hub75_clk)
    );

    always #20 sysclk = ~sysclk;  // 40 ns period

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Expected {r, g, b} for one row of a slice
    function automatic logic [8:0] expected_pixel(input mode_t m, input int t, input int row);
        logic [2:0] tv;
        logic [2:0] rv;
        logic [8:0] p;
        tv = 3'(t % 8);
        rv = 3'(row % 8);
        if (m == MODE_SPHERE) begin
            p = {tv, rv, tv ^ rv};
        end else if (row % 2 == 1) begin
            p = 9'h000;  // Odd rows dark
        end else begin
            p = {tv, tv, tv};
        end
        return p;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    // Rebuild both columns from the three planes and compare
    task automatic finish_frame();
        int         theta0;
        int         theta1;
        logic [8:0] got0;
        logic [8:0] got1;
        logic [8:0] exp0;
        logic [8:0] exp1;
        theta0 = int'(frame_addr);  // Slice index is the scan address here
        assert (theta0 < ROTATIONAL_RES) else
            report_error($sformatf("Fail hub75_addr exp below %h got %h", ROTATIONAL_RES, theta0));
        theta1 = (theta0 + ROTATIONAL_RES / 2) % ROTATIONAL_RES;
        for (int i = 0; i < NUM_ROWS; i++) begin
            for (int k = 0; k < 3; k++) begin
                got0[6 + k] = bits0[k][i][2];
                got0[3 + k] = bits0[k][i][1];
                got0[k]     = bits0[k][i][0];
                got1[6 + k] = bits1[k][i][2];
                got1[3 + k] = bits1[k][i][1];
                got1[k]     = bits1[k][i][0];
            end
            exp0 = expected_pixel(mode, theta0, i);
            exp1 = expected_pixel(mode, theta1, i);
            assert (got0 == exp0) else
                report_error($sformatf("Fail hub75_rgb0 row %h exp %h got %h", i, exp0, got0));
            assert (got1 == exp1) else
                report_error($sformatf("Fail hub75_rgb1 row %h exp %h got %h", i, exp1, got1));
        end
        frame_slices.push_back(theta0);
    endtask

    always @(posedge sysclk) begin
        if (reset) begin
            shift_cnt = 0;
            plane     = 0;
            oe_len    = 0;
            latch_cnt = 0;
            clk_q     = 1'b0;
            oe_q      = 1'b1;
        end else begin
            if (hub75_clk && !clk_q) begin
                assert (shift_cnt < NUM_ROWS) else
                    report_error("More shift clocks than rows before a latch pulse");
                if (plane == 0 && shift_cnt == 0) begin
                    frame_addr = hub75_addr;
                end
                bits0[plane][shift_cnt] = hub75_rgb0;
                bits1[plane][shift_cnt] = hub75_rgb1;
                shift_cnt++;
            end
            if (hub75_latch) begin
                assert (shift_cnt == NUM_ROWS) else
                    report_error($sformatf("Fail shift clocks exp %h got %h",
                                           NUM_ROWS, shift_cnt));
                latch_cnt++;
            end
            if (!hub75_oe) begin
                oe_len++;
            end else if (!oe_q) begin  // Window just closed
                assert (oe_len == (BASE_TIME << plane)) else
                    report_error($sformatf("Fail hub75_oe width exp %h got %h",
                                           BASE_TIME << plane, oe_len));
                assert (latch_cnt == 1) else
                    report_error("Output enable window not preceded by exactly one latch");
                oe_len    = 0;
                latch_cnt = 0;
                shift_cnt = 0;
                if (plane == 2) begin
                    finish_frame();
                    plane = 0;
                end else begin
                    plane++;
                end
            end
            clk_q = hub75_clk;
            oe_q  = hub75_oe;
        end
    end

    task automatic build_table();
        rev_table[0] = '{2400, MODE_STRIPES, 0};   // Not locked yet
        rev_table[1] = '{2400, MODE_STRIPES, 12};
        rng_state    = next_random(rng_state);
        rev_table[2] = '{2400 + int'(rng_state % 32'd3601), MODE_SPHERE, 12};
        rev_table[3] = '{6000, MODE_SPHERE, 12};
        rev_table[4] = '{3300, MODE_STRIPES, 7};   // Shorter turn
        rev_table[5] = '{2400, MODE_SPHERE, 9};
        rev_table[6] = '{5000, MODE_STRIPES, 12};  // Saturates at 11
    endtask

    task automatic check_revolution(input int idx, input int first);
        int count;
        count = frame_slices.size() - first;
        assert (count == rev_table[idx].slices) else
            report_error($sformatf("Fail frame count exp %h got %h",
                                   rev_table[idx].slices, count));
        for (int n = first; n < frame_slices.size(); n++) begin
            if (n == first) begin
                assert (frame_slices[n] == 0) else
                    report_error($sformatf("Fail first slice exp %h got %h", 0, frame_slices[n]));
            end else begin
                assert (frame_slices[n] > frame_slices[n - 1]) else
                    report_error("Frame slice indices did not increase within a revolution");
            end
        end
    endtask

    // One IR pulse of 3 cycles followed by the rest of the revolution
    task automatic apply_entry(input int idx);
        int   first;
        logic lock_exp;
        first      = frame_slices.size();
        mode       = rev_table[idx].mode;
        ir_tripped = 1'b1;
        for (int c = 1; c <= rev_table[idx].cycles; c++) begin
            @(posedge sysclk);
            lock_exp = (idx > 1) || (idx == 1 && c >= 3);
            assert (led[0] == ir_tripped) else
                report_error($sformatf("Fail led[0] exp %h got %h", ir_tripped, led[0]));
            assert (led[1] == lock_exp) else
                report_error($sformatf("Fail led[1] exp %h got %h", lock_exp, led[1]));
            #2;
            if (c == 3) begin
                ir_tripped = 1'b0;
            end
        end
        check_revolution(idx, first);
    endtask

    initial begin
        reset      = 1'b1;
        ir_tripped = 1'b0;
        mode       = MODE_STRIPES;
        build_table();
        limit_cycles = RESET_CYCLES + 20000;
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            limit_cycles = limit_cycles + rev_table[n].cycles;
        end
        repeat (RESET_CYCLES) @(posedge sysclk);
        #2;
        assert (hub75_oe == 1'b1) else
            report_error($sformatf("Fail hub75_oe exp 1 got %h", hub75_oe));
        assert (hub75_latch == 1'b0) else
            report_error($sformatf("Fail hub75_latch exp 0 got %h", hub75_latch));
        assert (led[1] == 1'b0) else
            report_error($sformatf("Fail led[1] exp 0 got %h", led[1]));
        assert (hub75_addr == 5'd0) else
            report_error($sformatf("Fail hub75_addr exp 0 got %h", hub75_addr));
        reset = 1'b0;
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            apply_entry(n);
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge sysclk);
        $display("Watchdog expired before all revolutions were checked");
        $display("Done: errors found");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire
